// ==== memop_pkg.sv ====
package memop_pkg;

    // Core datapath widths
    localparam int WORD_SIZE = 32;
    localparam int ADDR_SIZE = 32;
    localparam int REG_SIZE  = 5;

    typedef enum logic {
        LOAD,
        STORE
    } memop_op_e;

    typedef enum logic [1:0] {
        BYTE,
        HALF,
        WORD
    } memop_size_e;

    // Request from the ALU stage
    typedef struct packed {
        memop_op_e             op;
        memop_size_e           size;
        logic                  sign_ext;
        logic [ADDR_SIZE-1:0]  addr;
        logic [WORD_SIZE-1:0]  wdata;
        logic [REG_SIZE-1:0]   rf_waddr;
    } mem_req_t;

    // Load result towards write-back
    typedef struct packed {
        logic [WORD_SIZE-1:0]  data;
        logic [REG_SIZE-1:0]   rf_waddr;
    } mem_rsp_t;

endpackage

// ==== cache_pkg.sv ====
package cache_pkg;

    import memop_pkg::*;

    // Data array geometry
    localparam int DCACHE_LINES         = 16;
    localparam int DCACHE_INDEX_SIZE    = 4;
    localparam int DCACHE_WORD_SEL_SIZE = 2;
    localparam int DCACHE_BYTE_SIZE     = 2;
    localparam int DCACHE_LANE_SIZE     = WORD_SIZE << DCACHE_WORD_SEL_SIZE;
    localparam int DCACHE_BE_SIZE       = 1 << DCACHE_BYTE_SIZE;

    // 256 byte span, higher address bits alias
    localparam int DCACHE_ADDR_SIZE  = DCACHE_INDEX_SIZE + DCACHE_WORD_SEL_SIZE + DCACHE_BYTE_SIZE;
    localparam int DCACHE_WADDR_SIZE = DCACHE_INDEX_SIZE + DCACHE_WORD_SEL_SIZE;

    typedef struct packed {
        logic [DCACHE_INDEX_SIZE-1:0] index;
        logic [DCACHE_LANE_SIZE-1:0]  lane;
    } refill_t;

    // One word write into the array, byte granular
    typedef struct packed {
        logic [DCACHE_WADDR_SIZE-1:0] waddr;
        logic [WORD_SIZE-1:0]         data;
        logic [DCACHE_BE_SIZE-1:0]    be;
    } dcache_wr_t;

endpackage

// ==== dcache_data.sv ====
`timescale 1ns/1ps

module dcache_data
    import memop_pkg::*;
    import cache_pkg::*;
(
    input  logic                         clk_i,
    input  logic                         rst_n_i,

    // Load lookup
    input  logic [DCACHE_WADDR_SIZE-1:0] rd_addr_i,
    output logic [WORD_SIZE-1:0]         rd_data_o,

    // Drained stores
    input  logic                         wr_valid_i,
    input  dcache_wr_t                   wr_i,

    // Lane refill from the MMU
    input  logic                         refill_valid_i,
    input  refill_t                      refill_i
);

    logic [DCACHE_LANE_SIZE-1:0]     lines_q [DCACHE_LINES];

    logic [DCACHE_INDEX_SIZE-1:0]    rd_index;
    logic [DCACHE_WORD_SEL_SIZE-1:0] rd_word_sel;
    logic [DCACHE_INDEX_SIZE-1:0]    wr_index;
    logic [DCACHE_WORD_SEL_SIZE-1:0] wr_word_sel;
    logic [DCACHE_LANE_SIZE-1:0]     wr_lane;

    // Word address splits into line index and word within the lane
    assign rd_index    = rd_addr_i[DCACHE_WADDR_SIZE-1:DCACHE_WORD_SEL_SIZE];
    assign rd_word_sel = rd_addr_i[DCACHE_WORD_SEL_SIZE-1:0];
    assign wr_index    = wr_i.waddr[DCACHE_WADDR_SIZE-1:DCACHE_WORD_SEL_SIZE];
    assign wr_word_sel = wr_i.waddr[DCACHE_WORD_SEL_SIZE-1:0];

    // Asynchronous word read
    assign rd_data_o = lines_q[rd_index][rd_word_sel*WORD_SIZE +: WORD_SIZE];

    // Store lane with the enabled bytes replaced
    always_comb begin
        wr_lane = lines_q[wr_index];
        for (int b = 0; b < DCACHE_BE_SIZE; b++) begin
            if (wr_i.be[b]) begin
                wr_lane[wr_word_sel*WORD_SIZE + b*8 +: 8] = wr_i.data[b*8 +: 8];
            end
        end
    end

    // Refill wins over a drained store
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < DCACHE_LINES; i++) begin
                lines_q[i] <= '0;
            end
        end else if (refill_valid_i) begin
            lines_q[refill_i.index] <= refill_i.lane;
        end else if (wr_valid_i) begin
            lines_q[wr_index] <= wr_lane;
        end
    end

endmodule

// ==== store_buffer.sv ====
`timescale 1ns/1ps

module store_buffer
    import memop_pkg::*;
    import cache_pkg::*;
#(
    parameter int SB_DEPTH = 4
) (
    input  logic                         clk_i,
    input  logic                         rst_n_i,

    // Store from the memory stage
    input  logic                         push_i,
    input  dcache_wr_t                   push_i_data,

    // Load forwarding
    input  logic [DCACHE_WADDR_SIZE-1:0] lookup_addr_i,
    output logic [WORD_SIZE-1:0]         fwd_data_o,
    output logic [DCACHE_BE_SIZE-1:0]    fwd_mask_o,

    // Drain towards the data array
    input  logic                         drain_stall_i,
    output logic                         drain_valid_o,
    output dcache_wr_t                   drain_o,

    output logic                         full_o,
    output logic                         empty_o
);

    localparam int PTR_W = (SB_DEPTH > 1) ? $clog2(SB_DEPTH) : 1;

    logic [SB_DEPTH-1:0] valid_q;
    dcache_wr_t          entry_q [SB_DEPTH];
    logic [PTR_W-1:0]    head_q;
    logic [PTR_W-1:0]    tail_q;

    logic [SB_DEPTH-1:0] push_hit;
    logic [SB_DEPTH-1:0] look_hit;
    logic [PTR_W-1:0]    merge_idx;
    logic                push_merge;
    logic                keep_head;
    logic                pop;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(SB_DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    // Address match against every valid entry
    always_comb begin
        for (int i = 0; i < SB_DEPTH; i++) begin
            push_hit[i] = valid_q[i] && (entry_q[i].waddr == push_i_data.waddr);
            look_hit[i] = valid_q[i] && (entry_q[i].waddr == lookup_addr_i);
        end
    end

    // At most one entry holds a given word
    always_comb begin
        merge_idx  = '0;
        fwd_data_o = '0;
        fwd_mask_o = '0;
        for (int i = 0; i < SB_DEPTH; i++) begin
            if (push_hit[i]) begin
                merge_idx = PTR_W'(i);
            end
            if (look_hit[i]) begin
                fwd_data_o = entry_q[i].data;
                fwd_mask_o = entry_q[i].be;
            end
        end
    end

    assign push_merge = push_i && (|push_hit);

    // Oldest entry goes out unless a refill holds the array
    assign drain_valid_o = valid_q[head_q] && !drain_stall_i;
    assign drain_o       = entry_q[head_q];

    // A store merging into the draining head keeps it for one more pass
    assign keep_head = push_merge && (merge_idx == head_q);
    assign pop       = drain_valid_o && !keep_head;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_q <= '0;
            head_q  <= '0;
            tail_q  <= '0;
        end else begin
            if (pop) begin
                valid_q[head_q] <= 1'b0;
                head_q          <= next_ptr(head_q);
            end
            if (push_i && !push_merge) begin
                valid_q[tail_q] <= 1'b1;
                tail_q          <= next_ptr(tail_q);
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (push_merge) begin
            for (int b = 0; b < DCACHE_BE_SIZE; b++) begin
                if (push_i_data.be[b]) begin
                    entry_q[merge_idx].data[b*8 +: 8] <= push_i_data.data[b*8 +: 8];
                end
            end
            entry_q[merge_idx].be <= entry_q[merge_idx].be | push_i_data.be;
        end else if (push_i) begin
            entry_q[tail_q] <= push_i_data;
        end
    end

    assign full_o  = &valid_q;
    assign empty_o = ~|valid_q;

endmodule

// ==== mem_stage.sv ====
`timescale 1ns/1ps

module mem_stage
    import memop_pkg::*;
    import cache_pkg::*;
(
    input  logic                         clk_i,
    input  logic                         rst_n_i,

    // From the ALU stage
    input  logic                         req_valid_i,
    input  mem_req_t                     req_i,

    // Store buffer
    output logic                         sb_push_o,
    output dcache_wr_t                   sb_wr_o,
    output logic [DCACHE_WADDR_SIZE-1:0] lookup_addr_o,

    // Load sources
    input  logic [WORD_SIZE-1:0]         cache_word_i,
    input  logic [WORD_SIZE-1:0]         fwd_data_i,
    input  logic [DCACHE_BE_SIZE-1:0]    fwd_mask_i,

    // To write-back
    output logic                         rsp_valid_o,
    output mem_rsp_t                     rsp_o
);

    logic [DCACHE_BYTE_SIZE-1:0]  byte_off;
    logic [DCACHE_BE_SIZE-1:0]    be_base;
    logic [WORD_SIZE-1:0]         load_word;
    logic [WORD_SIZE-1:0]         load_shifted;
    logic [WORD_SIZE-1:0]         load_ext;
    logic                         is_load;

    assign byte_off      = req_i.addr[DCACHE_BYTE_SIZE-1:0];
    assign lookup_addr_o = req_i.addr[DCACHE_ADDR_SIZE-1:DCACHE_BYTE_SIZE];
    assign is_load       = req_valid_i && (req_i.op == LOAD);

    // Byte enable before lane alignment
    always_comb begin
        case (req_i.size)
            BYTE:    be_base = 4'b0001;
            HALF:    be_base = 4'b0011;
            WORD:    be_base = 4'b1111;
            default: be_base = '0;
        endcase
    end

    assign sb_push_o     = req_valid_i && (req_i.op == STORE);
    assign sb_wr_o.waddr = lookup_addr_o;
    assign sb_wr_o.be    = be_base << byte_off;
    assign sb_wr_o.data  = req_i.wdata << {byte_off, 3'b000};

    // Pending store bytes override the array word
    always_comb begin
        for (int b = 0; b < DCACHE_BE_SIZE; b++) begin
            load_word[b*8 +: 8] = fwd_mask_i[b] ? fwd_data_i[b*8 +: 8] : cache_word_i[b*8 +: 8];
        end
    end

    assign load_shifted = load_word >> {byte_off, 3'b000};

    always_comb begin
        case (req_i.size)
            BYTE:    load_ext = {{(WORD_SIZE-8){req_i.sign_ext & load_shifted[7]}},
                                load_shifted[7:0]};
            HALF:    load_ext = {{(WORD_SIZE-16){req_i.sign_ext & load_shifted[15]}},
                                load_shifted[15:0]};
            default: load_ext = load_shifted;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rsp_valid_o <= 1'b0;
        end else begin
            rsp_valid_o <= is_load;
        end
    end

    always_ff @(posedge clk_i) begin
        if (is_load) begin
            rsp_o.data     <= load_ext;
            rsp_o.rf_waddr <= req_i.rf_waddr;
        end
    end

endmodule

// ==== dmem_top.sv ====
`timescale 1ns/1ps

module dmem_top
    import memop_pkg::*;
    import cache_pkg::*;
#(
    parameter int SB_DEPTH = 4
) (
    input  logic     clk_i,
    input  logic     rst_n_i,

    input  logic     req_valid_i,
    input  mem_req_t req_i,
    input  logic     refill_valid_i,
    input  refill_t  refill_i,

    output logic     rsp_valid_o,
    output mem_rsp_t rsp_o,
    output logic     sb_full_o,
    output logic     sb_empty_o
);

    logic                         sb_push;
    dcache_wr_t                   sb_wr;
    logic [DCACHE_WADDR_SIZE-1:0] lookup_addr;
    logic [WORD_SIZE-1:0]         cache_word;
    logic [WORD_SIZE-1:0]         fwd_data;
    logic [DCACHE_BE_SIZE-1:0]    fwd_mask;
    logic                         drain_valid;
    dcache_wr_t                   drain;

    mem_stage mem_stage_inst (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .req_valid_i   (req_valid_i),
        .req_i         (req_i),
        .sb_push_o     (sb_push),
        .sb_wr_o       (sb_wr),
        .lookup_addr_o (lookup_addr),
        .cache_word_i  (cache_word),
        .fwd_data_i    (fwd_data),
        .fwd_mask_i    (fwd_mask),
        .rsp_valid_o   (rsp_valid_o),
        .rsp_o         (rsp_o)
    );

    // Refill strobe stalls the drain
    store_buffer #(
        .SB_DEPTH (SB_DEPTH)
    ) store_buffer_inst (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .push_i        (sb_push),
        .push_i_data   (sb_wr),
        .lookup_addr_i (lookup_addr),
        .fwd_data_o    (fwd_data),
        .fwd_mask_o    (fwd_mask),
        .drain_stall_i (refill_valid_i),
        .drain_valid_o (drain_valid),
        .drain_o       (drain),
        .full_o        (sb_full_o),
        .empty_o       (sb_empty_o)
    );

    dcache_data dcache_data_inst (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .rd_addr_i      (lookup_addr),
        .rd_data_o      (cache_word),
        .wr_valid_i     (drain_valid),
        .wr_i           (drain),
        .refill_valid_i (refill_valid_i),
        .refill_i       (refill_i)
    );

endmodule

// ==== dmem_checker.sv ====
`timescale 1ns/1ps

module dmem_checker
    import memop_pkg::*;
(
    input logic     clk_i,
    input logic     rst_n_i,
    input logic     req_valid_i,
    input mem_req_t req_i,
    input logic     refill_valid_i,
    input logic     rsp_valid_i,
    input logic     sb_full_i,
    input logic     sb_empty_i
);

    int unsigned assert_fails = 0;

    logic is_load;
    logic is_store;

    assign is_load  = req_valid_i && (req_i.op == LOAD);
    assign is_store = req_valid_i && (req_i.op == STORE);

    // Response exactly one cycle after each load, and never otherwise
    a_rsp_after_load: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        is_load |=> rsp_valid_i)
        else begin
            $error("load strobe without a response in the next cycle");
            assert_fails++;
        end

    a_rsp_has_load: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        rsp_valid_i |-> $past(is_load))
        else begin
            $error("response without a load strobe in the previous cycle");
            assert_fails++;
        end

    a_rsp_low_in_reset: assert property (@(posedge clk_i) !rst_n_i |-> !rsp_valid_i)
        else begin
            $error("rsp_valid_o high during reset");
            assert_fails++;
        end

    a_full_empty: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !(sb_full_i && sb_empty_i))
        else begin
            $error("store buffer reports full and empty at once");
            assert_fails++;
        end

    // Requester protocol
    a_no_store_full: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        is_store |-> !sb_full_i)
        else begin
            $error("store issued while the store buffer is full");
            assert_fails++;
        end

    a_refill_empty: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        refill_valid_i |-> sb_empty_i)
        else begin
            $error("refill issued while stores are pending");
            assert_fails++;
        end

endmodule

bind dmem_top dmem_checker dmem_checker_inst (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .req_valid_i    (req_valid_i),
    .req_i          (req_i),
    .refill_valid_i (refill_valid_i),
    .rsp_valid_i    (rsp_valid_o),
    .sb_full_i      (sb_full_o),
    .sb_empty_i     (sb_empty_o)
);

// ==== tb_dmem_top.sv ====
`timescale 1ns/1ps

module tb_dmem_top
    import memop_pkg::*;
    import cache_pkg::*;
();

    localparam int SB_DEPTH = 4;
    localparam int TIMEOUT  = 200;

    logic     clk_i;
    logic     rst_n_i;
    logic     req_valid_i;
    mem_req_t req_i;
    logic     refill_valid_i;
    refill_t  refill_i;
    logic     rsp_valid_o;
    mem_rsp_t rsp_o;
    logic     sb_full_o;
    logic     sb_empty_o;

    // Architectural byte view of the 256 byte span
    logic [7:0]  ref_mem [256];
    logic [31:0] lfsr_state;
    mem_rsp_t    exp_q [$];
    string       name_q [$];
    string       test_name;
    logic        full_seen;
    int          value_errors;
    int          other_errors;

    dmem_top #(
        .SB_DEPTH (SB_DEPTH)
    ) dmem_top_inst (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .req_valid_i    (req_valid_i),
        .req_i          (req_i),
        .refill_valid_i (refill_valid_i),
        .refill_i       (refill_i),
        .rsp_valid_o    (rsp_valid_o),
        .rsp_o          (rsp_o),
        .sb_full_o      (sb_full_o),
        .sb_empty_o     (sb_empty_o)
    );

    always #50 clk_i = ~clk_i;

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r = {r[30:0], lfsr_state[0]};
            lfsr_state = lfsr_state[0] ? (lfsr_state >> 1) ^ 32'h8020_0003 : lfsr_state >> 1;
        end
        return r;
    endfunction

    function automatic logic [31:0] align(input logic [31:0] addr, input memop_size_e size);
        case (size)
            HALF:    return {addr[31:1], 1'b0};
            WORD:    return {addr[31:2], 2'b00};
            default: return addr;
        endcase
    endfunction

    // Expected write-back value, little endian from the byte model
    function automatic logic [31:0] expected_load(input logic [31:0] addr,
                                                  input memop_size_e size, input logic sign);
        logic [31:0] w;
        for (int k = 0; k < 4; k++) begin
            w[k*8 +: 8] = ref_mem[8'(addr[7:0] + k)];
        end
        case (size)
            BYTE:    return sign ? {{24{w[7]}}, w[7:0]} : {24'd0, w[7:0]};
            HALF:    return sign ? {{16{w[15]}}, w[15:0]} : {16'd0, w[15:0]};
            default: return w;
        endcase
    endfunction

    task automatic go_idle();
        @(posedge clk_i);
        req_valid_i    <= 1'b0;
        refill_valid_i <= 1'b0;
    endtask

    task automatic send_load(input logic [31:0] addr, input memop_size_e size, input logic sign);
        mem_req_t r;
        mem_rsp_t e;
        r          = '0;
        r.op       = LOAD;
        r.size     = size;
        r.sign_ext = sign;
        r.addr     = addr;
        r.wdata    = rand_bits(32);
        r.rf_waddr = rand_bits(REG_SIZE);
        e.data     = expected_load(addr, size, sign);
        e.rf_waddr = r.rf_waddr;
        @(posedge clk_i);
        req_valid_i    <= 1'b1;
        refill_valid_i <= 1'b0;
        req_i          <= r;
        exp_q.push_back(e);
        name_q.push_back(test_name);
    endtask

    task automatic send_store(input logic [31:0] addr, input memop_size_e size,
                              input logic [31:0] data);
        mem_req_t r;
        int       waited;
        r       = '0;
        r.op    = STORE;
        r.size  = size;
        r.addr  = addr;
        r.wdata = data;
        waited  = 0;
        // No store into a full buffer
        @(negedge clk_i);
        while (sb_full_o && waited < TIMEOUT) begin
            @(negedge clk_i);
            waited++;
        end
        if (sb_full_o) begin
            $display("%s: store buffer never left the full state", test_name);
            other_errors++;
        end
        @(posedge clk_i);
        req_valid_i    <= 1'b1;
        refill_valid_i <= 1'b0;
        req_i          <= r;
        for (int k = 0; k < (size == WORD ? 4 : size == HALF ? 2 : 1); k++) begin
            ref_mem[8'(addr[7:0] + k)] = data[k*8 +: 8];
        end
    endtask

    task automatic wait_empty();
        int waited;
        waited = 0;
        go_idle();
        @(negedge clk_i);
        while (!sb_empty_o && waited < TIMEOUT) begin
            @(negedge clk_i);
            waited++;
        end
        if (!sb_empty_o) begin
            $display("%s: store buffer did not drain in %0d cycles", test_name, TIMEOUT);
            other_errors++;
        end
    endtask

    task automatic send_refill(input logic [DCACHE_INDEX_SIZE-1:0] index,
                               input logic [DCACHE_LANE_SIZE-1:0] lane);
        refill_t f;
        f.index = index;
        f.lane  = lane;
        wait_empty();
        @(posedge clk_i);
        req_valid_i    <= 1'b0;
        refill_valid_i <= 1'b1;
        refill_i       <= f;
        for (int k = 0; k < DCACHE_LANE_SIZE / 8; k++) begin
            ref_mem[{index, 4'(k)}] = lane[k*8 +: 8];
        end
    endtask

    task automatic wait_responses();
        int waited;
        waited = 0;
        go_idle();
        @(negedge clk_i);
        while (exp_q.size() != 0 && waited < TIMEOUT) begin
            @(negedge clk_i);
            waited++;
        end
        if (exp_q.size() != 0) begin
            $display("%0d load responses never arrived", exp_q.size());
            other_errors++;
        end
    endtask

    always @(negedge clk_i) begin
        if (sb_full_o) begin
            full_seen <= 1'b1;
        end
    end

    // Responses come back in issue order
    always @(negedge clk_i) begin
        mem_rsp_t e;
        string    n;
        if (rst_n_i && rsp_valid_o) begin
            if (exp_q.size() == 0) begin
                $display("Load response %h arrived with no load pending", rsp_o.data);
                other_errors++;
            end else begin
                e = exp_q.pop_front();
                n = name_q.pop_front();
                if (rsp_o.data !== e.data) begin
                    $display("ERROR %s: data expected %h, actual %h", n, e.data, rsp_o.data);
                    value_errors++;
                end
                if (rsp_o.rf_waddr !== e.rf_waddr) begin
                    $display("ERROR %s: rf_waddr expected %0d, actual %0d", n, e.rf_waddr,
                             rsp_o.rf_waddr);
                    value_errors++;
                end
            end
        end
    end

    initial begin
        logic [31:0]                  addr;
        logic [31:0]                  base;
        memop_size_e                  size;
        logic [DCACHE_INDEX_SIZE-1:0] index;
        int                           assert_errors;
        clk_i          = 1'b0;
        rst_n_i        = 1'b0;
        req_valid_i    = 1'b0;
        req_i          = '0;
        refill_valid_i = 1'b0;
        refill_i       = '0;
        lfsr_state     = 32'd75;
        value_errors   = 0;
        other_errors   = 0;
        full_seen      = 1'b0;
        foreach (ref_mem[i]) begin
            ref_mem[i] = 8'h00;
        end
        repeat (2) @(posedge clk_i);
        rst_n_i <= 1'b1;

        test_name = "reset_zero";
        @(negedge clk_i);
        if (!sb_empty_o || sb_full_o) begin
            $display("reset_zero: store buffer status wrong after reset");
            other_errors++;
        end
        for (int i = 0; i < 64; i++) begin
            addr      = rand_bits(32);
            addr[7:0] = {6'(i), 2'b00};
            send_load(addr, WORD, 1'b0);
        end

        test_name = "store_forward";
        for (int i = 0; i < 32; i++) begin
            size = memop_size_e'(rand_bits(2) % 3);
            addr = align(rand_bits(32), size);
            send_store(addr, size, rand_bits(32));
            send_load(align(addr, WORD), WORD, 1'b0);
        end

        // Bytes 01, 7f, ff, 80 cover both sides of the sign boundary
        test_name = "load_extend";
        send_store(32'h0000_0040, WORD, 32'h80FF_7F01);
        wait_empty();
        for (int i = 0; i < 8; i++) begin
            send_load(32'h40 + i / 2, BYTE, i[0]);
        end
        for (int i = 0; i < 4; i++) begin
            send_load(32'h40 + (i / 2) * 2, HALF, i[0]);
        end
        for (int i = 0; i < 64; i++) begin
            size = memop_size_e'(rand_bits(2) % 3);
            send_load(align(rand_bits(32), size), size, rand_bits(1));
        end

        test_name = "store_merge";
        addr      = align(rand_bits(32), WORD);
        full_seen = 1'b0;
        for (int i = 0; i < 4 * SB_DEPTH; i++) begin
            send_store(addr + i % 4, BYTE, rand_bits(8));
        end
        send_store(addr + 2, HALF, rand_bits(16));
        send_load(addr, WORD, 1'b0);
        wait_empty();
        if (full_seen) begin
            $display("store_merge: sb_full_o rose while storing to one word");
            other_errors++;
        end
        send_load(addr, WORD, 1'b0);

        test_name = "refill";
        index = rand_bits(DCACHE_INDEX_SIZE);
        send_refill(index, {rand_bits(32), rand_bits(32), rand_bits(32), rand_bits(32)});
        for (int w = 0; w < 4; w++) begin
            addr      = rand_bits(32);
            addr[7:0] = {index, 2'(w), 2'b00};
            send_load(addr, WORD, 1'b0);
        end

        test_name = "burst_drain";
        base = align(rand_bits(32), WORD);
        for (int i = 0; i < SB_DEPTH; i++) begin
            send_store(base + 4 * i, WORD, rand_bits(32));
        end
        wait_empty();
        for (int i = 0; i < SB_DEPTH; i++) begin
            send_load(base + 4 * i, WORD, 1'b0);
        end

        wait_responses();
        assert_errors = dmem_top_inst.dmem_checker_inst.assert_fails;
        $display("Errors: %0d value, %0d other, %0d assertion", value_errors, other_errors,
                 assert_errors);
        if (value_errors + other_errors + assert_errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// ==== sim.f ====
memop_pkg.sv
cache_pkg.sv
dcache_data.sv
store_buffer.sv
mem_stage.sv
dmem_top.sv
dmem_checker.sv
tb_dmem_top.sv

// ==== Bender.yml ====
package:
  name: dmem

sources:
  - memop_pkg.sv
  - cache_pkg.sv
  - dcache_data.sv
  - store_buffer.sv
  - mem_stage.sv
  - dmem_top.sv
  - target: simulation
    files:
      - dmem_checker.sv
      - tb_dmem_top.sv
